// File: Bender.yml
package:
  name: alu_cluster

export_include_dirs:
  - .

sources:
  - alu_pkg.sv
  - operand_forward.sv
  - alu_lane.sv
  - result_bus.sv
  - alu_cluster.sv
  - target: test
    files:
      - tb_alu_cluster.sv

// File: alu_cluster.f
+incdir+.
alu_pkg.sv
operand_forward.sv
alu_lane.sv
result_bus.sv
alu_cluster.sv
tb_alu_cluster.sv

// File: alu_cluster.sv
`timescale 1ns/10ps
`include "alu_cluster_config.svh"

module alu_cluster (
  input  logic              clk,
  input  logic              rst,
  input  logic              except,
  input  logic              issue_valid [`ALU_LANES],
  input  alu_pkg::op_t      issue_op    [`ALU_LANES],
  input  alu_pkg::data_t    issue_a     [`ALU_LANES],
  input  alu_pkg::data_t    issue_b     [`ALU_LANES],
  input  alu_pkg::fwd_sel_t issue_a_sel [`ALU_LANES],
  input  alu_pkg::fwd_sel_t issue_b_sel [`ALU_LANES],
  input  alu_pkg::tag_t     issue_tag   [`ALU_LANES],
  output logic              ret_done    [`ALU_LANES],
  output alu_pkg::data_t    ret_result  [`ALU_LANES],
  output alu_pkg::flags_t   ret_flags   [`ALU_LANES],
  output alu_pkg::tag_t     ret_tag     [`ALU_LANES]
);

  logic            stage_valid [`ALU_LANES];
  alu_pkg::op_t    stage_op    [`ALU_LANES];
  alu_pkg::data_t  stage_a     [`ALU_LANES];
  alu_pkg::data_t  stage_b     [`ALU_LANES];
  alu_pkg::tag_t   stage_tag   [`ALU_LANES];
  logic            lane_valid  [`ALU_LANES];
  alu_pkg::data_t  lane_result [`ALU_LANES];
  alu_pkg::flags_t lane_flags  [`ALU_LANES];
  alu_pkg::tag_t   lane_tag    [`ALU_LANES];
  alu_pkg::data_t  dly_result  [`ALU_LANES];

  operand_forward fwd0 (
    .clk         (clk),
    .rst         (rst),
    .except      (except),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_a     (issue_a),
    .issue_b     (issue_b),
    .issue_a_sel (issue_a_sel),
    .issue_b_sel (issue_b_sel),
    .issue_tag   (issue_tag),
    .bus_result  (ret_result),  // the retiring result is also the current forward source
    .dly_result  (dly_result),
    .stage_valid (stage_valid),
    .stage_op    (stage_op),
    .stage_a     (stage_a),
    .stage_b     (stage_b),
    .stage_tag   (stage_tag)
  );

  for (genvar g = 0; g < `ALU_LANES; g++) begin : g_lane
    alu_lane lane (
      .stage_valid (stage_valid[g]),
      .stage_op    (stage_op[g]),
      .stage_a     (stage_a[g]),
      .stage_b     (stage_b[g]),
      .stage_tag   (stage_tag[g]),
      .lane_valid  (lane_valid[g]),
      .lane_result (lane_result[g]),
      .lane_flags  (lane_flags[g]),
      .lane_tag    (lane_tag[g])
    );
  end

  result_bus bus0 (
    .clk         (clk),
    .rst         (rst),
    .lane_valid  (lane_valid),
    .lane_result (lane_result),
    .lane_flags  (lane_flags),
    .lane_tag    (lane_tag),
    .bus_valid   (ret_done),
    .bus_result  (ret_result),
    .bus_flags   (ret_flags),
    .bus_tag     (ret_tag),
    .dly_valid   (),  // forwarding takes the delayed word without its strobe
    .dly_result  (dly_result)
  );

endmodule

// File: alu_cluster_config.svh
`ifndef ALU_CLUSTER_CONFIG_SVH
`define ALU_CLUSTER_CONFIG_SVH

// cluster shape
`define ALU_LANES   3
`define ALU_DATA_W  64
`define ALU_TAG_W   6
`define ALU_SEL_W   3  // 0 is the register file, then current bus, then delayed bus
`define ALU_OP_W    4

// opcode values
`define ALU_OP_ADD64  4'd0
`define ALU_OP_SUB64  4'd1
`define ALU_OP_ADD32  4'd2
`define ALU_OP_SUB32  4'd3
`define ALU_OP_AND    4'd4
`define ALU_OP_OR     4'd5
`define ALU_OP_XOR    4'd6
`define ALU_OP_SHL64  4'd7
`define ALU_OP_SHR64  4'd8
`define ALU_OP_SAR64  4'd9
`define ALU_OP_SHL32  4'd10
`define ALU_OP_SHR32  4'd11
`define ALU_OP_SAR32  4'd12  // highest legal opcode

// flag bit positions
`define ALU_FLAG_Z  0
`define ALU_FLAG_S  1
`define ALU_FLAG_C  2
`define ALU_FLAG_V  3

`endif

// File: alu_lane.sv
`timescale 1ns/10ps
`include "alu_cluster_config.svh"

module alu_lane (
  input  logic            stage_valid,
  input  alu_pkg::op_t    stage_op,
  input  alu_pkg::data_t  stage_a,
  input  alu_pkg::data_t  stage_b,
  input  alu_pkg::tag_t   stage_tag,
  output logic            lane_valid,
  output alu_pkg::data_t  lane_result,
  output alu_pkg::flags_t lane_flags,
  output alu_pkg::tag_t   lane_tag
);

  localparam int HALF = `ALU_DATA_W / 2;
  localparam int SH_W = $clog2(`ALU_DATA_W);

  logic                 sz32;
  logic                 add_sub;
  logic                 is_sub;
  logic                 shift;
  logic                 arith;
  logic                 dir;
  logic [SH_W-1:0]      amt;
  alu_pkg::data_t       b_eff;
  logic [`ALU_DATA_W:0] sum64;
  logic [HALF:0]        sum32;
  alu_pkg::data_t       shift_res;
  logic                 carry;
  logic                 ovf;

  assign sz32 = stage_op == `ALU_OP_ADD32 || stage_op == `ALU_OP_SUB32 ||
                stage_op == `ALU_OP_SHL32 || stage_op == `ALU_OP_SHR32 ||
                stage_op == `ALU_OP_SAR32;
  assign add_sub = stage_op <= `ALU_OP_SUB32;
  assign is_sub  = stage_op == `ALU_OP_SUB64 || stage_op == `ALU_OP_SUB32;
  assign shift   = stage_op >= `ALU_OP_SHL64 && stage_op <= `ALU_OP_SAR32;
  assign arith   = stage_op == `ALU_OP_SAR64 || stage_op == `ALU_OP_SAR32;
  assign dir     = stage_op != `ALU_OP_SHL64 && stage_op != `ALU_OP_SHL32;  // high for right shifts

  // 32-bit shifts only look at five bits of the count
  assign amt = sz32 ? {1'b0, stage_b[SH_W-2:0]} : stage_b[SH_W-1:0];

  assign b_eff = stage_b ^ {`ALU_DATA_W{is_sub}};  // subtract is a plus not b plus one
  assign sum64 = {1'b0, stage_a} + {1'b0, b_eff} + is_sub;
  assign sum32 = {1'b0, stage_a[HALF-1:0]} + {1'b0, b_eff[HALF-1:0]} + is_sub;

  always_comb begin
    shift_res = '0;
    if (sz32) begin
      if (!dir) begin
        shift_res[HALF-1:0] = stage_a[HALF-1:0] << amt;
      end else if (arith) begin
        shift_res[HALF-1:0] = $signed(stage_a[HALF-1:0]) >>> amt;
      end else begin
        shift_res[HALF-1:0] = stage_a[HALF-1:0] >> amt;
      end
    end else begin
      if (!dir) begin
        shift_res = stage_a << amt;
      end else if (arith) begin
        shift_res = $signed(stage_a) >>> amt;
      end else begin
        shift_res = stage_a >> amt;
      end
    end
  end

  always_comb begin
    lane_result = '0;
    carry       = 1'b0;
    ovf         = 1'b0;
    if (add_sub) begin
      if (sz32) begin
        lane_result[HALF-1:0] = sum32[HALF-1:0];  // upper half stays zero
        carry = sum32[HALF] ^ is_sub;  // a missing carry out of a subtract is a borrow
        ovf   = (stage_a[HALF-1] == b_eff[HALF-1]) && (sum32[HALF-1] != stage_a[HALF-1]);
      end else begin
        lane_result = sum64[`ALU_DATA_W-1:0];
        carry = sum64[`ALU_DATA_W] ^ is_sub;
        ovf   = (stage_a[`ALU_DATA_W-1] == b_eff[`ALU_DATA_W-1]) &&
                (sum64[`ALU_DATA_W-1] != stage_a[`ALU_DATA_W-1]);
      end
    end else if (shift) begin
      lane_result = shift_res;
    end else begin
      case (stage_op)
        `ALU_OP_AND: lane_result = stage_a & stage_b;
        `ALU_OP_OR:  lane_result = stage_a | stage_b;
        `ALU_OP_XOR: lane_result = stage_a ^ stage_b;
        default:     lane_result = '0;
      endcase
    end
  end

  // narrow results are zero extended so the zero test can use the whole word
  always_comb begin
    lane_flags[`ALU_FLAG_Z] = lane_result == '0;
    lane_flags[`ALU_FLAG_S] = sz32 ? lane_result[HALF-1] : lane_result[`ALU_DATA_W-1];
    lane_flags[`ALU_FLAG_C] = carry;
    lane_flags[`ALU_FLAG_V] = ovf;
  end

  assign lane_valid = stage_valid;
  assign lane_tag   = stage_tag;

  always_comb begin
    op_legal: assert final (stage_valid !== 1'b1 || stage_op <= `ALU_OP_SAR32);
  end

endmodule

// File: alu_pkg.sv
`include "alu_cluster_config.svh"

package alu_pkg;

  // operand or result word
  typedef logic [`ALU_DATA_W-1:0] data_t;

  typedef logic [`ALU_OP_W-1:0] op_t;

  // destination register tag
  typedef logic [`ALU_TAG_W-1:0] tag_t;

  // operand source select
  typedef logic [`ALU_SEL_W-1:0] fwd_sel_t;

  // zero, sign, carry and overflow
  typedef logic [`ALU_FLAG_V:0] flags_t;

endpackage

// File: operand_forward.sv
`timescale 1ns/10ps
`include "alu_cluster_config.svh"

module operand_forward (
  input  logic               clk,
  input  logic               rst,
  input  logic               except,
  input  logic               issue_valid [`ALU_LANES],
  input  alu_pkg::op_t       issue_op    [`ALU_LANES],
  input  alu_pkg::data_t     issue_a     [`ALU_LANES],
  input  alu_pkg::data_t     issue_b     [`ALU_LANES],
  input  alu_pkg::fwd_sel_t  issue_a_sel [`ALU_LANES],
  input  alu_pkg::fwd_sel_t  issue_b_sel [`ALU_LANES],
  input  alu_pkg::tag_t      issue_tag   [`ALU_LANES],
  input  alu_pkg::data_t     bus_result  [`ALU_LANES],
  input  alu_pkg::data_t     dly_result  [`ALU_LANES],
  output logic               stage_valid [`ALU_LANES],
  output alu_pkg::op_t       stage_op    [`ALU_LANES],
  output alu_pkg::data_t     stage_a     [`ALU_LANES],
  output alu_pkg::data_t     stage_b     [`ALU_LANES],
  output alu_pkg::tag_t      stage_tag   [`ALU_LANES]
);

  alu_pkg::data_t src_word [2*`ALU_LANES];  // current bus words first, then the delayed ones
  alu_pkg::data_t a_mux    [`ALU_LANES];
  alu_pkg::data_t b_mux    [`ALU_LANES];

  // select k+1 picks bus word k and select 0 keeps the register file value
  function automatic alu_pkg::data_t pick_src(
    input alu_pkg::fwd_sel_t sel,
    input alu_pkg::data_t    rf,
    input alu_pkg::data_t    words [2*`ALU_LANES]
  );
    alu_pkg::data_t word;
    word = rf;
    for (int k = 0; k < 2*`ALU_LANES; k++) begin
      if (sel == alu_pkg::fwd_sel_t'(k + 1)) begin
        word = words[k];
      end
    end
    return word;
  endfunction

  always_comb begin
    for (int i = 0; i < `ALU_LANES; i++) begin
      src_word[i]             = bus_result[i];
      src_word[i + `ALU_LANES] = dly_result[i];  // bus as it was one cycle ago
    end
  end

  always_comb begin
    for (int i = 0; i < `ALU_LANES; i++) begin
      a_mux[i] = pick_src(issue_a_sel[i], issue_a[i], src_word);
      b_mux[i] = pick_src(issue_b_sel[i], issue_b[i], src_word);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `ALU_LANES; i++) begin
        stage_valid[i] <= 1'b0;
      end
    end else begin
      for (int i = 0; i < `ALU_LANES; i++) begin
        stage_valid[i] <= issue_valid[i] & ~except;  // an exception kills this cycle's issue
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < `ALU_LANES; i++) begin
      stage_op[i]  <= issue_op[i];
      stage_a[i]   <= a_mux[i];
      stage_b[i]   <= b_mux[i];
      stage_tag[i] <= issue_tag[i];
    end
  end

  for (genvar g = 0; g < `ALU_LANES; g++) begin : g_sel_chk
    sel_legal: assert property (@(posedge clk) disable iff (rst)
      issue_valid[g] |-> (issue_a_sel[g] <= 2*`ALU_LANES && issue_b_sel[g] <= 2*`ALU_LANES));
  end

endmodule

// File: result_bus.sv
`timescale 1ns/10ps
`include "alu_cluster_config.svh"

module result_bus (
  input  logic            clk,
  input  logic            rst,
  input  logic            lane_valid  [`ALU_LANES],
  input  alu_pkg::data_t  lane_result [`ALU_LANES],
  input  alu_pkg::flags_t lane_flags  [`ALU_LANES],
  input  alu_pkg::tag_t   lane_tag    [`ALU_LANES],
  output logic            bus_valid   [`ALU_LANES],
  output alu_pkg::data_t  bus_result  [`ALU_LANES],
  output alu_pkg::flags_t bus_flags   [`ALU_LANES],
  output alu_pkg::tag_t   bus_tag     [`ALU_LANES],
  output logic            dly_valid   [`ALU_LANES],
  output alu_pkg::data_t  dly_result  [`ALU_LANES]
);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `ALU_LANES; i++) begin
        bus_valid[i] <= 1'b0;
        dly_valid[i] <= 1'b0;
      end
    end else begin
      for (int i = 0; i < `ALU_LANES; i++) begin
        bus_valid[i] <= lane_valid[i];
        dly_valid[i] <= bus_valid[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < `ALU_LANES; i++) begin
      bus_result[i] <= lane_result[i];
      bus_flags[i]  <= lane_flags[i];
      bus_tag[i]    <= lane_tag[i];
      dly_result[i] <= bus_result[i];  // kept one more cycle for late forwarding
    end
  end

  // an unknown issue strobe upstream would show up here two cycles later
  for (genvar g = 0; g < `ALU_LANES; g++) begin : g_valid_chk
    valid_known: assert property (@(posedge clk) disable iff (rst)
      !$isunknown(bus_valid[g]));
  end

endmodule

// File: tb_alu_cluster.sv
`timescale 1ns/10ps
`include "alu_cluster_config.svh"

module tb_alu_cluster;

  localparam int W         = `ALU_DATA_W;
  localparam int H         = `ALU_DATA_W / 2;
  localparam int L         = `ALU_LANES;
  localparam int QD        = 16;  // far deeper than the two operations a lane keeps in flight
  localparam int T1_REPS   = 4;
  localparam int T2_CYC    = 200;
  localparam int T3_CYC    = 60;
  localparam int T4_CYC    = 60;
  localparam int T5_CYC    = 120;
  localparam int TOTAL_OPS = L * (13 * T1_REPS + T2_CYC + T3_CYC + T4_CYC + T5_CYC);

  logic              clk;
  logic              rst;
  logic              except;
  logic              issue_valid [L];
  alu_pkg::op_t      issue_op    [L];
  alu_pkg::data_t    issue_a     [L];
  alu_pkg::data_t    issue_b     [L];
  alu_pkg::fwd_sel_t issue_a_sel [L];
  alu_pkg::fwd_sel_t issue_b_sel [L];
  alu_pkg::tag_t     issue_tag   [L];
  logic              ret_done    [L];
  alu_pkg::data_t    ret_result  [L];
  alu_pkg::flags_t   ret_flags   [L];
  alu_pkg::tag_t     ret_tag     [L];

  integer seed;
  int     cyc;
  int     err_cnt;
  int     err_base;
  int     pass_cnt;
  int     fail_cnt;

  // model copy of the data path from the issue register to the delayed bus
  alu_pkg::data_t  m_issue [L];
  alu_pkg::data_t  m_stage [L];
  alu_pkg::data_t  m_cur   [L];
  alu_pkg::data_t  m_dly   [L];

  // expected retires per lane, kept as ring buffers
  alu_pkg::data_t  q_res [L][QD];
  alu_pkg::flags_t q_flg [L][QD];
  alu_pkg::tag_t   q_tag [L][QD];
  int              q_cyc [L][QD];
  int              q_wr  [L];
  int              q_rd  [L];

  alu_cluster dut0 (
    .clk         (clk),
    .rst         (rst),
    .except      (except),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_a     (issue_a),
    .issue_b     (issue_b),
    .issue_a_sel (issue_a_sel),
    .issue_b_sel (issue_b_sel),
    .issue_tag   (issue_tag),
    .ret_done    (ret_done),
    .ret_result  (ret_result),
    .ret_flags   (ret_flags),
    .ret_tag     (ret_tag)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  initial begin
    #((TOTAL_OPS + 100) * 8);
    $display("watchdog expired at %0t before all tests finished", $time);
    $display("test failed");
    $finish;
  end

  function automatic int urand(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // edge values show up often so that the flags get exercised
  function automatic alu_pkg::data_t rand_word();
    int kind;
    kind = urand(8);
    case (kind)
      0: return '0;
      1: return '1;
      2: return {1'b1, {(W-1){1'b0}}};
      3: return alu_pkg::data_t'(urand(70));  // small values double as shift counts
      4: return {$random(seed), 32'h8000_0000};
      default: return {$random(seed), $random(seed)};
    endcase
  endfunction

  function automatic alu_pkg::data_t resolve(input alu_pkg::fwd_sel_t sel,
                                             input alu_pkg::data_t rf);
    if (sel == 0) begin
      return rf;
    end else if (sel <= L) begin
      return m_cur[sel - 1];
    end
    return m_dly[sel - 1 - L];
  endfunction

  task automatic model_op(input alu_pkg::op_t op, input alu_pkg::data_t a,
                          input alu_pkg::data_t b, output alu_pkg::data_t res,
                          output alu_pkg::flags_t flg);
    logic [W:0]   wide;
    logic [H:0]   narrow;
    logic [H-1:0] a32;
    logic [H-1:0] b32;
    logic         c;
    logic         v;
    logic         w32;
    a32 = a[H-1:0];
    b32 = b[H-1:0];
    res = '0;
    c   = 1'b0;
    v   = 1'b0;
    w32 = 1'b0;
    case (op)
      `ALU_OP_ADD64: begin
        wide = {1'b0, a} + {1'b0, b};
        res  = wide[W-1:0];
        c    = wide[W];
        v    = (a[W-1] == b[W-1]) && (res[W-1] != a[W-1]);
      end
      `ALU_OP_SUB64: begin
        res = a - b;
        c   = a < b;  // borrow
        v   = (a[W-1] != b[W-1]) && (res[W-1] != a[W-1]);
      end
      `ALU_OP_ADD32: begin
        narrow = {1'b0, a32} + {1'b0, b32};
        res    = {{H{1'b0}}, narrow[H-1:0]};
        c      = narrow[H];
        v      = (a32[H-1] == b32[H-1]) && (narrow[H-1] != a32[H-1]);
        w32    = 1'b1;
      end
      `ALU_OP_SUB32: begin
        res = {{H{1'b0}}, a32 - b32};
        c   = a32 < b32;
        v   = (a32[H-1] != b32[H-1]) && (res[H-1] != a32[H-1]);
        w32 = 1'b1;
      end
      `ALU_OP_AND:   res = a & b;
      `ALU_OP_OR:    res = a | b;
      `ALU_OP_XOR:   res = a ^ b;
      `ALU_OP_SHL64: res = a << b[5:0];
      `ALU_OP_SHR64: res = a >> b[5:0];
      `ALU_OP_SAR64: res = $signed(a) >>> b[5:0];
      `ALU_OP_SHL32: begin
        res = {{H{1'b0}}, a32 << b[4:0]};
        w32 = 1'b1;
      end
      `ALU_OP_SHR32: begin
        res = {{H{1'b0}}, a32 >> b[4:0]};
        w32 = 1'b1;
      end
      `ALU_OP_SAR32: begin
        res = {{H{1'b0}}, $signed(a32) >>> b[4:0]};
        w32 = 1'b1;
      end
      default: res = '0;
    endcase
    flg[`ALU_FLAG_Z] = res == '0;
    flg[`ALU_FLAG_S] = w32 ? res[H-1] : res[W-1];
    flg[`ALU_FLAG_C] = c;
    flg[`ALU_FLAG_V] = v;
  endtask

  task automatic check_result(input int lane, input alu_pkg::data_t got,
                              input alu_pkg::data_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: lane %0d result %h, expected %h", $time, lane, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_flags(input int lane, input alu_pkg::flags_t got,
                             input alu_pkg::flags_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: lane %0d flags %b, expected %b", $time, lane, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_tag(input int lane, input alu_pkg::tag_t got, input alu_pkg::tag_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: lane %0d tag %0d, expected %0d", $time, lane, got, exp);
      err_cnt++;
    end
  endtask

  // vmode 0 idle, 1 all lanes, 2 random lanes; smode 0 register file, 1 current bus,
  // 2 delayed bus, 3 any source
  task automatic issue_cycle(input int vmode, input int smode, input logic exc,
                             input int fix_op);
    alu_pkg::data_t    a_val;
    alu_pkg::data_t    b_val;
    alu_pkg::data_t    res;
    alu_pkg::flags_t   flg;
    alu_pkg::op_t      op;
    alu_pkg::fwd_sel_t a_sel;
    alu_pkg::fwd_sel_t b_sel;
    alu_pkg::tag_t     tag;
    logic              v;
    int                slot;
    @(posedge clk);
    #1;
    for (int i = 0; i < L; i++) begin
      m_dly[i]   = m_cur[i];
      m_cur[i]   = m_stage[i];
      m_stage[i] = m_issue[i];
    end
    except = exc;
    for (int i = 0; i < L; i++) begin
      v     = vmode == 1 || (vmode == 2 && urand(4) != 0);
      op    = fix_op >= 0 ? alu_pkg::op_t'(fix_op) : alu_pkg::op_t'(urand(13));
      a_val = rand_word();
      b_val = rand_word();
      case (smode)
        1: begin
          a_sel = alu_pkg::fwd_sel_t'(1 + urand(L));
          b_sel = alu_pkg::fwd_sel_t'(urand(L + 1));
        end
        2: begin
          a_sel = alu_pkg::fwd_sel_t'(1 + L + urand(L));
          b_sel = alu_pkg::fwd_sel_t'(1 + L + urand(L));
        end
        3: begin
          a_sel = alu_pkg::fwd_sel_t'(urand(2 * L + 1));
          b_sel = alu_pkg::fwd_sel_t'(urand(2 * L + 1));
        end
        default: begin
          a_sel = '0;
          b_sel = '0;
        end
      endcase
      tag = alu_pkg::tag_t'(urand(64));
      // the lane computes even when nothing valid is issued, and that word still reaches the bus
      model_op(op, resolve(a_sel, a_val), resolve(b_sel, b_val), res, flg);
      m_issue[i] = res;
      if (v && !exc) begin
        slot = q_wr[i] % QD;
        q_res[i][slot] = res;
        q_flg[i][slot] = flg;
        q_tag[i][slot] = tag;
        q_cyc[i][slot] = cyc;
        q_wr[i]++;
      end
      issue_valid[i] = v;
      issue_op[i]    = op;
      issue_a[i]     = a_val;
      issue_b[i]     = b_val;
      issue_a_sel[i] = a_sel;
      issue_b_sel[i] = b_sel;
      issue_tag[i]   = tag;
    end
  endtask

  task automatic check_quiet();
    for (int i = 0; i < L; i++) begin
      if (ret_done[i] !== 1'b0) begin
        $display("ret_done on lane %0d is not low at %0t during or just after reset", i, $time);
        err_cnt++;
      end
    end
  endtask

  task automatic drain(input string name);
    int n;
    repeat (3) issue_cycle(0, 0, 1'b0, -1);
    for (int i = 0; i < L; i++) begin
      if (q_wr[i] != q_rd[i]) begin
        $display("lane %0d still holds %0d operations that never retired", i, q_wr[i] - q_rd[i]);
        err_cnt++;
        q_rd[i] = q_wr[i];
      end
    end
    n = err_cnt - err_base;
    $display("%s: %s, %0d errors", name, n == 0 ? "ok" : "FAILED", n);
    if (n == 0) begin
      pass_cnt++;
    end else begin
      fail_cnt++;
    end
    err_base = err_cnt;
  endtask

  always @(negedge clk) begin
    int slot;
    for (int i = 0; i < L; i++) begin
      if (ret_done[i] === 1'b1) begin
        if (q_wr[i] == q_rd[i]) begin
          $display("lane %0d retired a result at %0t with no operation outstanding", i, $time);
          err_cnt++;
        end else begin
          slot = q_rd[i] % QD;
          check_result(i, ret_result[i], q_res[i][slot]);
          check_flags(i, ret_flags[i], q_flg[i][slot]);
          check_tag(i, ret_tag[i], q_tag[i][slot]);
          if (cyc != q_cyc[i][slot] + 2) begin
            $display("lane %0d retired in cycle %0d an operation issued in cycle %0d", i, cyc,
                     q_cyc[i][slot]);
            err_cnt++;
          end
          q_rd[i]++;
        end
      end
    end
  end

  initial begin
    seed     = 36465;
    cyc      = 0;
    err_cnt  = 0;
    err_base = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    rst      = 1'b1;
    except   = 1'b0;
    for (int i = 0; i < L; i++) begin
      issue_valid[i] = 1'b0;
      issue_op[i]    = '0;
      issue_a[i]     = '0;
      issue_b[i]     = '0;
      issue_a_sel[i] = '0;
      issue_b_sel[i] = '0;
      issue_tag[i]   = '0;
      m_issue[i]     = '0;
      m_stage[i]     = '0;
      m_cur[i]       = '0;
      m_dly[i]       = '0;
      q_wr[i]        = 0;
      q_rd[i]        = 0;
    end
    repeat (16) issue_cycle(0, 0, 1'b0, -1);
    rst = 1'b0;
    repeat (3) issue_cycle(0, 0, 1'b0, -1);

    for (int op = 0; op <= 12; op++) begin
      repeat (T1_REPS) issue_cycle(1, 0, 1'b0, op);
    end
    drain("opcode sweep");

    repeat (T2_CYC) issue_cycle(1, 3, 1'b0, -1);
    drain("back to back issue");

    repeat (T3_CYC) issue_cycle(1, 1, 1'b0, -1);
    drain("current bus forwarding");

    repeat (T4_CYC) issue_cycle(1, 2, 1'b0, -1);
    drain("delayed bus forwarding");

    repeat (T5_CYC) issue_cycle(2, 3, urand(4) == 0, -1);
    drain("exception cancel");

    issue_cycle(1, 0, 1'b0, -1);
    issue_cycle(1, 0, 1'b0, -1);
    rst = 1'b1;
    for (int i = 0; i < L; i++) begin
      q_wr[i] = q_rd[i];  // reset drops the two operations still in the pipeline
    end
    repeat (16) begin
      @(negedge clk);
      check_quiet();
      issue_cycle(0, 0, 1'b0, -1);
    end
    rst = 1'b0;
    repeat (2) begin
      @(negedge clk);
      check_quiet();
      issue_cycle(0, 0, 1'b0, -1);
    end
    drain("reset");

    $display("summary: %0d tests clean, %0d tests with errors", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
